// ==== fir_pkg.sv ====
// fixed 11-tap filter; every word is 32-bit signed and all arithmetic wraps to 32 bits
`default_nettype none

package fir_pkg;

    // bus and datapath widths
    localparam int data_width    = 32;
    localparam int addr_width    = 12;

    // filter length, also the depth of the sample history
    localparam int num_taps      = 11;
    localparam int tap_idx_width = 4;

    // samples, coefficients and results
    typedef logic signed [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [tap_idx_width-1:0] tap_idx_t;

    // control and status word
    localparam addr_t reg_ctrl_addr = 12'h000;
    // tap i lives at base + 4*i
    localparam addr_t reg_tap_base  = 12'h040;

    // bit positions inside the control word
    localparam int ctrl_start_bit = 0;
    localparam int ctrl_done_bit  = 1;
    localparam int ctrl_idle_bit  = 2;

    // one stream beat between blocks
    typedef struct packed {
        data_t data;
        logic  last;
    } stream_beat_t;

    // coefficient lookup from the engine
    typedef struct packed {
        tap_idx_t idx;
        logic     valid;
    } tap_req_t;

endpackage

`default_nettype wire

// ==== fir_axil_regs.sv ====
// one register access at a time with writes ahead of reads; no write response; taps are writable only while idle
`default_nettype none

module fir_axil_regs (
    input  wire                    axis_clk,
    input  wire                    axis_rst_n,
    // write channel
    input  wire                    awvalid,
    input  wire fir_pkg::addr_t    awaddr,
    input  wire                    wvalid,
    input  wire fir_pkg::data_t    wdata,
    output logic                   awready,
    output logic                   wready,
    // read channel
    input  wire                    arvalid,
    input  wire fir_pkg::addr_t    araddr,
    input  wire                    rready,
    output logic                   arready,
    output logic                   rvalid,
    output fir_pkg::data_t         rdata,
    // coefficient lookup from the engine
    input  wire fir_pkg::tap_req_t tap_req,
    output fir_pkg::data_t         tap_coef,
    // run control
    input  wire                    run_done,
    output logic                   running,
    output logic                   run_clear
);

    typedef enum logic [1:0] {
        port_idle,
        port_wr,
        port_raddr,
        port_rdata
    } port_state_t;

    port_state_t    state;
    fir_pkg::addr_t raddr;
    fir_pkg::data_t read_word;
    fir_pkg::data_t coef [fir_pkg::num_taps];
    logic           ap_start;
    logic           ap_done;
    logic           ap_idle;
    logic           wr_fire;
    logic           start_req;

    // tap window covers base .. base + 4*num_taps - 1
    function automatic logic is_tap(input fir_pkg::addr_t a);
        return (a >= fir_pkg::reg_tap_base) &&
               (a < fir_pkg::reg_tap_base + fir_pkg::addr_t'(4 * fir_pkg::num_taps));
    endfunction

    // byte offset to word index, low two bits ignored
    function automatic fir_pkg::tap_idx_t tap_of(input fir_pkg::addr_t a);
        fir_pkg::addr_t off;
        off = a - fir_pkg::reg_tap_base;
        return fir_pkg::tap_idx_t'(off[fir_pkg::addr_width-1:2]);
    endfunction

    // handshake strobes decode straight from the state
    assign awready = (state == port_wr);
    assign wready  = (state == port_wr);
    assign arready = (state == port_raddr);
    assign rvalid  = (state == port_rdata);

    // write takes effect on the ready edge
    assign wr_fire   = (state == port_wr) && awvalid && wvalid;
    assign start_req = wr_fire && (awaddr == fir_pkg::reg_ctrl_addr) &&
                       wdata[fir_pkg::ctrl_start_bit] && ap_idle;

    // start pulse also wipes the sample history
    assign run_clear = ap_start;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= port_idle;
        end else begin
            case (state)
                port_idle: begin
                    // both write halves must be present together
                    if (awvalid && wvalid) begin
                        state <= port_wr;
                    end else if (arvalid) begin
                        state <= port_raddr;
                    end
                end
                port_wr: begin
                    state <= port_idle;
                end
                port_raddr: begin
                    state <= port_rdata;
                end
                port_rdata: begin
                    // hold rdata until the host takes it
                    if (rready) begin
                        state <= port_idle;
                    end
                end
                default: begin
                    state <= port_idle;
                end
            endcase
        end
    end

    // flags as seen by a ctrl read
    always_comb begin
        read_word = '0;
        if (raddr == fir_pkg::reg_ctrl_addr) begin
            read_word[fir_pkg::ctrl_start_bit] = ap_start;
            read_word[fir_pkg::ctrl_done_bit]  = ap_done;
            read_word[fir_pkg::ctrl_idle_bit]  = ap_idle;
        end else if (is_tap(raddr)) begin
            read_word = coef[tap_of(raddr)];
        end
    end

    always_ff @(posedge axis_clk) begin
        if (state == port_idle && arvalid) begin
            raddr <= araddr;
        end
        if (state == port_raddr) begin
            rdata <= read_word;
        end
        // coefficients frozen during a run
        if (wr_fire && ap_idle && is_tap(awaddr)) begin
            coef[tap_of(awaddr)] <= wdata;
        end
    end

    // engine lookup, zero when idle or out of range
    always_comb begin
        tap_coef = '0;
        if (tap_req.valid && tap_req.idx < fir_pkg::tap_idx_t'(fir_pkg::num_taps)) begin
            tap_coef = coef[tap_req.idx];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
            running  <= 1'b0;
        end else begin
            // start reads back as 1 only for its pulse cycle
            ap_start <= start_req;
            if (start_req) begin
                ap_idle <= 1'b0;
                ap_done <= 1'b0;
            end
            // stream side opens one cycle after the clear
            if (ap_start) begin
                running <= 1'b1;
            end
            if (run_done) begin
                running <= 1'b0;
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (state == port_raddr && raddr == fir_pkg::reg_ctrl_addr) begin
                // done is read-to-clear, rdata already holds it
                ap_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fir_sample_window.sv ====
// history holds the last 11 samples of the current run; older positions read as zero
`default_nettype none

module fir_sample_window (
    input  wire                        axis_clk,
    input  wire                        axis_rst_n,
    // stream slave
    input  wire                        ss_tvalid,
    input  wire fir_pkg::data_t        ss_tdata,
    input  wire                        ss_tlast,
    output logic                       ss_tready,
    // run control
    input  wire                        running,
    input  wire                        run_clear,
    input  wire                        ready_for_sample,
    // new sample to the engine
    output fir_pkg::stream_beat_t      sample_beat,
    output logic                       sample_valid,
    // history lookup
    input  wire fir_pkg::tap_idx_t     hist_idx,
    output fir_pkg::data_t             hist_data
);

    fir_pkg::data_t    hist [fir_pkg::num_taps];
    fir_pkg::tap_idx_t wr_ptr;
    fir_pkg::tap_idx_t fill;
    fir_pkg::tap_idx_t slot;
    logic [4:0]        slot_raw;
    logic              take;

    // only one sample in the engine at a time
    assign ss_tready = running && ready_for_sample;
    assign take      = ss_tvalid && ss_tready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr       <= '0;
            fill         <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= take;
            if (run_clear) begin
                wr_ptr <= '0;
                fill   <= '0;
            end else if (take) begin
                // pointer wraps at num_taps
                if (wr_ptr == fir_pkg::tap_idx_t'(fir_pkg::num_taps - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                // fill saturates once the window is full
                if (fill != fir_pkg::tap_idx_t'(fir_pkg::num_taps)) begin
                    fill <= fill + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (take) begin
            hist[wr_ptr] <= ss_tdata;
            sample_beat  <= '{data: ss_tdata, last: ss_tlast};
        end
    end

    // newest sample sits one slot behind wr_ptr
    assign slot_raw = 5'(wr_ptr) + 5'(fir_pkg::num_taps - 1) - 5'(hist_idx);
    assign slot     = (slot_raw >= 5'(fir_pkg::num_taps)) ?
                      fir_pkg::tap_idx_t'(slot_raw - 5'(fir_pkg::num_taps)) :
                      fir_pkg::tap_idx_t'(slot_raw);

    // positions not yet filled this run count as zero
    assign hist_data = (hist_idx < fill) ? hist[slot] : '0;

endmodule

`default_nettype wire

// ==== fir_mac_engine.sv ====
// one tap per cycle over a single multiplier; a finished sum waits here until the result stage is free
`default_nettype none

module fir_mac_engine (
    input  wire                        axis_clk,
    input  wire                        axis_rst_n,
    // new sample from the window
    input  wire fir_pkg::stream_beat_t sample_beat,
    input  wire                        sample_valid,
    output logic                       ready_for_sample,
    // coefficient lookup
    output fir_pkg::tap_req_t          tap_req,
    input  wire fir_pkg::data_t        tap_coef,
    // history lookup, k samples back
    output fir_pkg::tap_idx_t          hist_idx,
    input  wire fir_pkg::data_t        hist_data,
    // finished result
    output fir_pkg::stream_beat_t      result_beat,
    output logic                       result_valid,
    input  wire                        stage_free
);

    typedef enum logic [1:0] {
        eng_idle,
        eng_calc,
        eng_hold
    } eng_state_t;

    eng_state_t        state;
    fir_pkg::tap_idx_t step;
    fir_pkg::data_t    acc;
    fir_pkg::data_t    operand;
    fir_pkg::data_t    product;
    fir_pkg::data_t    sum;
    logic              last_q;
    logic              mac_en;

    // tap 0 runs in the sample_valid cycle itself
    assign mac_en = sample_valid || (state == eng_calc);

    // closed while a sample is landing, computing or waiting
    assign ready_for_sample = (state == eng_idle) && !sample_valid;

    // step indexes both coefficient and history
    assign tap_req  = '{idx: step, valid: mac_en};
    assign hist_idx = step;

    // newest sample straight from the beat
    assign operand = sample_valid ? sample_beat.data : hist_data;
    // both wrap to 32 bits
    assign product = tap_coef * operand;
    assign sum     = (state == eng_calc) ? acc + product : product;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= eng_idle;
            step   <= '0;
            last_q <= 1'b0;
        end else begin
            case (state)
                eng_idle: begin
                    if (sample_valid) begin
                        state  <= eng_calc;
                        step   <= fir_pkg::tap_idx_t'(1);
                        // last flag rides along to the result
                        last_q <= sample_beat.last;
                    end
                end
                eng_calc: begin
                    if (step == fir_pkg::tap_idx_t'(fir_pkg::num_taps - 1)) begin
                        state <= eng_hold;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                eng_hold: begin
                    // result stage takes it on this edge
                    if (stage_free) begin
                        state <= eng_idle;
                    end
                end
                default: begin
                    state <= eng_idle;
                end
            endcase
        end
    end

    // accumulator restarts from the tap 0 product
    always_ff @(posedge axis_clk) begin
        if (mac_en) begin
            acc <= sum;
        end
    end

    assign result_beat  = '{data: acc, last: last_q};
    assign result_valid = (state == eng_hold);

endmodule

`default_nettype wire

// ==== fir_result_stage.sv ====
// one-entry output buffer; a new result enters only after the held one drains
`default_nettype none

module fir_result_stage (
    input  wire                        axis_clk,
    input  wire                        axis_rst_n,
    // result from the engine
    input  wire fir_pkg::stream_beat_t result_beat,
    input  wire                        result_valid,
    output logic                       stage_free,
    // stream master
    input  wire                        sm_tready,
    output logic                       sm_tvalid,
    output fir_pkg::data_t             sm_tdata,
    output logic                       sm_tlast,
    // end of run
    output logic                       run_done
);

    fir_pkg::stream_beat_t beat;
    logic                  full;
    logic                  load;

    assign stage_free = !full;
    assign load       = result_valid && !full;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full     <= 1'b0;
            run_done <= 1'b0;
        end else begin
            // pulse after the last beat leaves
            run_done <= sm_tvalid && sm_tready && sm_tlast;
            if (load) begin
                full <= 1'b1;
            end else if (sm_tready) begin
                full <= 1'b0;
            end
        end
    end

    // beat stays put under back-pressure
    always_ff @(posedge axis_clk) begin
        if (load) begin
            beat <= result_beat;
        end
    end

    assign sm_tvalid = full;
    assign sm_tdata  = beat.data;
    assign sm_tlast  = beat.last;

endmodule

`default_nettype wire

// ==== fir_top.sv ====
// 11-tap FIR behind a register port and two streams; run ends on the beat marked tlast
`default_nettype none

module fir_top (
    input  wire                 axis_clk,
    input  wire                 axis_rst_n,
    // register write
    input  wire                 awvalid,
    output wire                 awready,
    input  wire fir_pkg::addr_t awaddr,
    input  wire                 wvalid,
    output wire                 wready,
    input  wire fir_pkg::data_t wdata,
    // register read
    input  wire                 arvalid,
    output wire                 arready,
    input  wire fir_pkg::addr_t araddr,
    output wire                 rvalid,
    input  wire                 rready,
    output fir_pkg::data_t      rdata,
    // stream slave
    input  wire                 ss_tvalid,
    output wire                 ss_tready,
    input  wire fir_pkg::data_t ss_tdata,
    input  wire                 ss_tlast,
    // stream master
    output wire                 sm_tvalid,
    input  wire                 sm_tready,
    output fir_pkg::data_t      sm_tdata,
    output wire                 sm_tlast
);

    fir_pkg::tap_req_t     tap_req;
    fir_pkg::data_t        tap_coef;
    fir_pkg::tap_idx_t     hist_idx;
    fir_pkg::data_t        hist_data;
    fir_pkg::stream_beat_t sample_beat;
    fir_pkg::stream_beat_t result_beat;
    wire                   sample_valid;
    wire                   ready_for_sample;
    wire                   result_valid;
    wire                   stage_free;
    wire                   running;
    wire                   run_clear;
    wire                   run_done;

    // host side and coefficient file
    fir_axil_regs u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .tap_req    (tap_req),
        .tap_coef   (tap_coef),
        .run_done   (run_done),
        .running    (running),
        .run_clear  (run_clear)
    );

    // input stream and history
    fir_sample_window u_window (
        .axis_clk         (axis_clk),
        .axis_rst_n       (axis_rst_n),
        .ss_tvalid        (ss_tvalid),
        .ss_tdata         (ss_tdata),
        .ss_tlast         (ss_tlast),
        .ss_tready        (ss_tready),
        .running          (running),
        .run_clear        (run_clear),
        .ready_for_sample (ready_for_sample),
        .sample_beat      (sample_beat),
        .sample_valid     (sample_valid),
        .hist_idx         (hist_idx),
        .hist_data        (hist_data)
    );

    fir_mac_engine u_engine (
        .axis_clk         (axis_clk),
        .axis_rst_n       (axis_rst_n),
        .sample_beat      (sample_beat),
        .sample_valid     (sample_valid),
        .ready_for_sample (ready_for_sample),
        .tap_req          (tap_req),
        .tap_coef         (tap_coef),
        .hist_idx         (hist_idx),
        .hist_data        (hist_data),
        .result_beat      (result_beat),
        .result_valid     (result_valid),
        .stage_free       (stage_free)
    );

    // output stream
    fir_result_stage u_result (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .result_beat  (result_beat),
        .result_valid (result_valid),
        .stage_free   (stage_free),
        .sm_tready    (sm_tready),
        .sm_tvalid    (sm_tvalid),
        .sm_tdata     (sm_tdata),
        .sm_tlast     (sm_tlast),
        .run_done     (run_done)
    );

endmodule

`default_nettype wire

// ==== tb_fir_checker.sv ====
// reference model of taps, flags and history; every handshake is taken at the rising edge
`default_nettype none

module tb_fir_checker (
    input wire        axis_clk,
    input wire        axis_rst_n,
    input wire        awvalid,
    input wire        awready,
    input wire [11:0] awaddr,
    input wire        wvalid,
    input wire        wready,
    input wire [31:0] wdata,
    input wire        arvalid,
    input wire        arready,
    input wire [11:0] araddr,
    input wire        rvalid,
    input wire        rready,
    input wire [31:0] rdata,
    input wire        ss_tvalid,
    input wire        ss_tready,
    input wire [31:0] ss_tdata,
    input wire        ss_tlast,
    input wire        sm_tvalid,
    input wire        sm_tready,
    input wire [31:0] sm_tdata,
    input wire        sm_tlast
);

    int checks = 0;
    int errors = 0;
    int tests = 0;
    int out_count = 0;
    int test_base = 0;
    // model state
    fir_pkg::data_t coef_m [fir_pkg::num_taps];
    fir_pkg::data_t hist_m [fir_pkg::num_taps];
    // expected output beats, last flag on top
    logic [32:0]    exp_q [$];
    logic [31:0]    read_exp = '0;
    logic           idle_m = 1'b1;
    logic           done_m = 1'b0;
    // done lands two edges after the last beat leaves
    logic           done_pipe = 1'b0;

    // tap i at base + 4*i, -1 outside the tap window
    function automatic int tap_slot(input logic [11:0] a);
        int off;
        off = int'(a) - int'(fir_pkg::reg_tap_base);
        if (off < 0 || off >= 4 * fir_pkg::num_taps) begin
            return -1;
        end
        return off / 4;
    endfunction

    // sum of coef[k] times the sample k back, wrapped
    function automatic fir_pkg::data_t filter_out();
        fir_pkg::data_t acc;
        acc = '0;
        for (int k = 0; k < fir_pkg::num_taps; k++) begin
            acc = acc + coef_m[k] * hist_m[k];
        end
        return acc;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    // one line per finished test
    task automatic end_test(input string name);
        if (exp_q.size() != 0) begin
            note_failure($sformatf("%0d expected output beats never appeared", exp_q.size()));
            exp_q.delete();
        end
        tests++;
        if (errors == test_base) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_base);
        end
        test_base = errors;
    endtask

    always @(posedge axis_clk) begin
        logic        fin;
        logic        start;
        int          slot;
        logic [32:0] beat;
        if (!axis_rst_n) begin
            idle_m    = 1'b1;
            done_m    = 1'b0;
            done_pipe = 1'b0;
            exp_q.delete();
            for (int k = 0; k < fir_pkg::num_taps; k++) begin
                hist_m[k] = '0;
            end
        end else begin
            fin       = done_pipe;
            done_pipe = sm_tvalid && sm_tready && sm_tlast;
            if (rvalid && rready) begin
                compare("rdata", rdata, read_exp);
            end
            // read value is fixed at the address handshake
            if (arvalid && arready) begin
                slot = tap_slot(araddr);
                if (araddr == fir_pkg::reg_ctrl_addr) begin
                    read_exp = '0;
                    read_exp[fir_pkg::ctrl_done_bit] = done_m;
                    read_exp[fir_pkg::ctrl_idle_bit] = idle_m;
                    if (!fin) begin
                        done_m = 1'b0;
                    end
                end else if (slot >= 0) begin
                    read_exp = coef_m[slot];
                end else begin
                    read_exp = '0;
                end
            end
            // writes count only while idle
            start = 1'b0;
            if (awvalid && awready && wvalid && wready && idle_m) begin
                slot = tap_slot(awaddr);
                if (awaddr == fir_pkg::reg_ctrl_addr && wdata[fir_pkg::ctrl_start_bit]) begin
                    start = 1'b1;
                end else if (slot >= 0) begin
                    coef_m[slot] = wdata;
                end
            end
            if (fin) begin
                done_m = 1'b1;
                idle_m = 1'b1;
            end
            // new run starts from an empty history
            if (start) begin
                idle_m = 1'b0;
                done_m = 1'b0;
                for (int k = 0; k < fir_pkg::num_taps; k++) begin
                    hist_m[k] = '0;
                end
            end
            if (sm_tvalid && sm_tready) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    note_failure("output beat arrived with no sample pending");
                end else begin
                    beat = exp_q.pop_front();
                    compare("sm_tdata", sm_tdata, beat[31:0]);
                    compare("sm_tlast", {31'b0, sm_tlast}, {31'b0, beat[32]});
                end
            end
            // newest sample at position 0
            if (ss_tvalid && ss_tready) begin
                for (int k = fir_pkg::num_taps - 1; k > 0; k--) begin
                    hist_m[k] = hist_m[k-1];
                end
                hist_m[0] = ss_tdata;
                exp_q.push_back({ss_tlast, filter_out()});
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_fir.sv ====
// drives on the falling edge; random data from a fixed-seed LCG; a watchdog bounds the run
`default_nettype none

module tb_fir;

    localparam int total_beats     = 12 + 40 + 6 + 15;
    localparam int watchdog_cycles = total_beats * 40 + 1000;

    logic           axis_clk = 1'b0;
    logic           axis_rst_n;
    logic           awvalid;
    logic           wvalid;
    logic           arvalid;
    logic           rready;
    logic [11:0]    awaddr;
    logic [11:0]    araddr;
    logic [31:0]    wdata;
    logic           ss_tvalid;
    logic           ss_tlast;
    logic [31:0]    ss_tdata;
    logic           sm_tready;
    wire            awready;
    wire            wready;
    wire            arready;
    wire            rvalid;
    wire  [31:0]    rdata;
    wire            ss_tready;
    wire            sm_tvalid;
    wire            sm_tlast;
    wire  [31:0]    sm_tdata;
    logic [31:0]    seed;
    logic [31:0]    stim [$];
    fir_pkg::data_t taps [fir_pkg::num_taps];

    always #4 axis_clk = ~axis_clk;

    fir_top dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    tb_fir_checker chk (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper bits only, the low LCG bits repeat quickly
    function automatic int rand_below(input int m);
        return int'((next_random() >> 16) % m);
    endfunction

    function automatic logic [11:0] tap_address(input int i);
        return fir_pkg::reg_tap_base + 12'(4 * i);
    endfunction

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        @(negedge axis_clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(negedge axis_clk);
        while (!awready) begin
            @(negedge axis_clk);
        end
        // ready edge has passed
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge axis_clk);
        while (!arready) begin
            @(negedge axis_clk);
        end
        @(negedge axis_clk);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge axis_clk);
        end
        data   = rdata;
        rready = 1'b1;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic load_taps();
        for (int i = 0; i < fir_pkg::num_taps; i++) begin
            taps[i] = rand_below(16) - 8;
            write_reg(tap_address(i), taps[i]);
        end
    endtask

    task automatic start_run();
        write_reg(fir_pkg::reg_ctrl_addr, 32'h1);
    endtask

    // sends stim, returns once every output has been accepted
    task automatic send_stream(input bit gaps, input bit bp);
        int n;
        int idx;
        int base;
        bit taking;
        n      = stim.size();
        idx    = 0;
        base   = chk.out_count;
        taking = 1'b0;
        while (chk.out_count - base < n) begin
            @(negedge axis_clk);
            // beat went in at the last rising edge
            if (taking) begin
                idx++;
            end
            sm_tready = bp ? (rand_below(4) != 0) : 1'b1;
            if (idx < n) begin
                // valid holds until the beat is taken
                if (!ss_tvalid || taking) begin
                    ss_tvalid = gaps ? (rand_below(3) != 0) : 1'b1;
                end
                ss_tdata = stim[idx];
                ss_tlast = (idx == n - 1);
            end else begin
                ss_tvalid = 1'b0;
                ss_tlast  = 1'b0;
            end
            taking = ss_tvalid && ss_tready;
        end
        ss_tvalid = 1'b0;
        sm_tready = 1'b1;
    endtask

    // poll the control word until ap_idle is back
    task automatic wait_idle(output logic [31:0] word);
        int tries;
        tries = 0;
        word  = '0;
        while (!word[fir_pkg::ctrl_idle_bit] && tries < 50) begin
            read_reg(fir_pkg::reg_ctrl_addr, word);
            tries++;
        end
        if (!word[fir_pkg::ctrl_idle_bit]) begin
            chk.note_failure("ap_idle did not return after the last output beat");
        end
    endtask

    task automatic random_samples(input int n);
        stim.delete();
        repeat (n) begin
            stim.push_back(rand_below(256) - 128);
        end
    endtask

    initial begin
        logic [31:0] word;
        seed       = 32'hf7ae;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        awaddr     = '0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b1;
        repeat (8) @(negedge axis_clk);
        axis_rst_n = 1'b1;

        // only ap_idle after reset
        read_reg(fir_pkg::reg_ctrl_addr, word);
        chk.compare("rdata", word, 32'h4);
        load_taps();
        for (int i = 0; i < fir_pkg::num_taps; i++) begin
            read_reg(tap_address(i), word);
            chk.compare("rdata", word, taps[i]);
        end
        chk.end_test("coefficient readback");

        // impulse then eleven zeros
        start_run();
        stim.delete();
        stim.push_back(32'd1);
        repeat (11) begin
            stim.push_back(32'd0);
        end
        send_stream(1'b0, 1'b0);
        wait_idle(word);
        chk.end_test("impulse response");

        start_run();
        random_samples(40);
        send_stream(1'b1, 1'b1);
        wait_idle(word);
        chk.end_test("random stream with back-pressure");

        // status read in the middle of a run
        start_run();
        random_samples(6);
        fork
            send_stream(1'b0, 1'b1);
            begin
                read_reg(fir_pkg::reg_ctrl_addr, word);
                chk.compare("ap_idle", {31'b0, word[fir_pkg::ctrl_idle_bit]}, 32'h0);
            end
        join
        wait_idle(word);
        chk.compare("ap_done", {31'b0, word[fir_pkg::ctrl_done_bit]}, 32'h1);
        read_reg(fir_pkg::reg_ctrl_addr, word);
        chk.compare("ap_done", {31'b0, word[fir_pkg::ctrl_done_bit]}, 32'h0);
        chk.compare("ap_idle", {31'b0, word[fir_pkg::ctrl_idle_bit]}, 32'h1);
        chk.end_test("status flags");

        // new taps, and a tap write that must be ignored mid-run
        load_taps();
        start_run();
        random_samples(15);
        fork
            send_stream(1'b1, 1'b0);
            write_reg(tap_address(3), 32'h55);
        join
        wait_idle(word);
        read_reg(tap_address(3), word);
        chk.compare("rdata", word, taps[3]);
        chk.end_test("restart clears history");

        $display("summary: %0d tests, %0d checks, %0d errors", chk.tests, chk.checks, chk.errors);
        if (chk.errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (watchdog_cycles) @(posedge axis_clk);
        $display("timeout: the run was still busy after %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
fir_pkg.sv
fir_axil_regs.sv
fir_sample_window.sv
fir_mac_engine.sv
fir_result_stage.sv
fir_top.sv
tb_fir_checker.sv
tb_fir.sv

// ==== Bender.yml ====
package:
  name: fir_filter

sources:
  - fir_pkg.sv
  - fir_axil_regs.sv
  - fir_sample_window.sv
  - fir_mac_engine.sv
  - fir_result_stage.sv
  - fir_top.sv
  - target: test
    files:
      - tb_fir_checker.sv
      - tb_fir.sv
